/* alu_top.f */
+incdir+design
design/alu_op_pkg.sv
design/alu_flag_pkg.sv
design/alu_operand_if.sv
design/alu_operand_stage.sv
design/alu_arith_unit.sv
design/alu_logic_unit.sv
design/alu_result_stage.sv
design/alu_top.sv
dv/alu_checker.sv
dv/alu_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module alu_tb \
	-f alu_top.f -o alu_sim > build.log 2>&1 \
	&& ./obj_dir/alu_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }

grep -q "\*\* FAIL \*\*" sim.log \
	&& { echo "simulation failed, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* dv/alu_tb.sv */
`timescale 1ns/100ps

module alu_tb;

	localparam time CLK_PERIOD = 40ns;
	localparam logic [15:0] SEED = 16'd62936;
	// reset cycles plus ops per test plus drain
	localparam int TEST_CYCLES = 10 + 40 + 40 + 32 + 32 + 24 + 20 + 6 * 4;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic clk;
	logic reset;
	logic en;
	logic log;
	logic [1:0] hc;
	logic [2:0] sc;
	logic sat;
	logic [15:0] x_in;
	logic [15:0] y_in;
	logic [15:0] result;
	logic az;
	logic an;
	logic ac;
	logic av;
	logic out_valid;

	logic [15:0] lfsr;
	logic model_ac;         // carry of the last issued op
	logic [19:0] exp_q[$];  // {data, z, n, c, v}
	int errors;
	int tests_run;
	int tests_failed;
	int err_at_start;
	int cycles;

	alu_top alu_top_inst
	(
		.clk(clk),
		.reset(reset),
		.en(en),
		.log(log),
		.hc(hc),
		.sc(sc),
		.sat(sat),
		.x_in(x_in),
		.y_in(y_in),
		.result(result),
		.az(az),
		.an(an),
		.ac(ac),
		.av(av),
		.out_valid(out_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ********************************************************************
	// stimulus LFSR x^16+x^14+x^13+x^11+1
	// ********************************************************************
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < n; i++)
			w = {w[14:0], lfsr_bit()}; // one step per bit
		return w;
	endfunction

	// reference model over the {hc, sc} code
	function automatic logic [19:0] model_op(input logic lg, input logic [4:0] code,
		input logic st, input logic [15:0] x, input logic [15:0] y, input logic ci);
		logic [16:0] s;
		logic [15:0] d;
		logic z;
		logic n;
		logic c;
		logic v;
		logic cmp;
		logic pos;
		d = '0;
		c = 1'b0;
		v = 1'b0;
		cmp = 1'b0;
		n = 1'b0;
		z = 1'b0;
		if (lg)
		begin
			case (code)
				5'b00_000: d = x & y;
				5'b00_001: d = x | y;
				5'b00_010: d = x ^ y;
				5'b11_000: d = ~x;
				default: d = '0;
			endcase
		end
		else
		begin
			case (code)
				5'b00_000, 5'b00_010:
				begin
					s = {1'b0, x} + {1'b0, y} + (code[1] ? {16'd0, ci} : 17'd0);
					d = s[15:0];
					c = s[16];
					v = (x[15] == y[15]) && (d[15] != x[15]);
				end
				5'b00_001, 5'b00_011:
				begin
					d = code[1] ? x - y + {15'd0, ci} - 16'd1 : x - y;
					c = code[1] ? ({1'b0, x} + {16'd0, ci}) > {1'b0, y} : (x >= y); // no borrow
					v = (x[15] != y[15]) && (d[15] != x[15]);
				end
				5'b00_101:
				begin
					d = x;
					cmp = 1'b1;
					z = (x == y);
					n = $signed(x) < $signed(y);
				end
				5'b01_001: d = ($signed(x) < $signed(y)) ? x : y; // min
				5'b01_011: d = ($signed(x) < $signed(y)) ? y : x; // max
				5'b10_001:
				begin
					d = -x;
					c = (x == 16'h0000);
					v = (x == 16'h8000);
				end
				5'b11_001:
				begin
					d = x[15] ? -x : x;
					v = (x == 16'h8000);
				end
				default: d = '0;
			endcase
		end
		if (st && v)
		begin
			pos = d[15]; // wrapped sign bit is flipped by the overflow
			d = pos ? 16'h7fff : 16'h8000;
		end
		if (!cmp)
		begin
			n = d[15];
			z = (d == '0);
		end
		return {d, z, n, c, v};
	endfunction

	task automatic send_op(input logic lg, input logic [4:0] code, input logic st,
		input logic [15:0] x, input logic [15:0] y);
		logic [19:0] e;
		e = model_op(lg, code, st, x, y, model_ac);
		model_ac = e[1];
		exp_q.push_back(e);
		@(posedge clk);
		#2;
		en = 1'b1;
		log = lg;
		{hc, sc} = code;
		sat = st;
		x_in = x;
		y_in = y;
	endtask

	// drop en and wait for every result
	task automatic drain_ops();
		@(posedge clk);
		#2;
		en = 1'b0;
		while (exp_q.size() > 0)
			@(posedge clk);
	endtask

	task automatic check_field(input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		if (exp_v !== act_v)
		begin
			$display("** Error %s: expected %h, got %h", name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == err_at_start)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_at_start);
		end
	endtask

	// ********************************************************************
	// result monitor samples at the falling edge
	// ********************************************************************
	always @(negedge clk)
	begin
		logic [19:0] e;
		if (!reset && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("out_valid came with no operation pending");
				errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				check_field("result", e[19:4], result);
				check_field("az", {15'd0, e[3]}, {15'd0, az});
				check_field("an", {15'd0, e[2]}, {15'd0, an});
				check_field("ac", {15'd0, e[1]}, {15'd0, ac});
				check_field("av", {15'd0, e[0]}, {15'd0, av});
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	// ********************************************************************
	// directed tests
	// ********************************************************************
	task automatic test_logic();
		logic [4:0] codes [4];
		codes = '{5'b00_000, 5'b00_001, 5'b00_010, 5'b11_000};
		err_at_start = errors;
		for (int i = 0; i < 40; i++)
			send_op(1'b1, codes[rand_bits(2)], 1'b0, rand_bits(16), rand_bits(16));
		drain_ops();
		report_test("logic ops");
	endtask

	task automatic test_addsub();
		err_at_start = errors;
		for (int i = 0; i < 40; i++)
			send_op(1'b0, {4'b0000, lfsr_bit()}, 1'b0, rand_bits(16), rand_bits(16));
		drain_ops();
		report_test("add and subtract");
	endtask

	task automatic test_carry();
		err_at_start = errors;
		send_op(1'b0, 5'b00_000, 1'b0, 16'hffff, 16'h0001); // low word carries out
		send_op(1'b0, 5'b00_010, 1'b0, 16'h1234, 16'h0000);
		for (int i = 0; i < 5; i++)
		begin
			send_op(1'b0, 5'b00_000, 1'b0, rand_bits(16), rand_bits(16));
			send_op(1'b0, 5'b00_010, 1'b0, rand_bits(16), rand_bits(16));
		end
		for (int i = 0; i < 6; i++)
		begin
			send_op(1'b0, 5'b00_001, 1'b0, rand_bits(16), rand_bits(16));
			send_op(1'b0, 5'b00_011, 1'b0, rand_bits(16), rand_bits(16));
		end
		for (int i = 0; i < 8; i++)
			send_op(1'b0, {4'b0001, i[0]}, 1'b0, rand_bits(16), rand_bits(16));
		drain_ops();
		report_test("carry chain");
	endtask

	task automatic test_cmp();
		logic [4:0] codes [3];
		logic [1:0] k;
		codes = '{5'b00_101, 5'b01_001, 5'b01_011};
		err_at_start = errors;
		for (int i = 0; i < 20; i++)
		begin
			k = 2'(rand_bits(2));
			send_op(1'b0, codes[k % 3], 1'b0, rand_bits(16), rand_bits(16));
		end
		for (int j = 0; j < 3; j++)
		begin
			send_op(1'b0, codes[j], 1'b0, 16'h5a5a, 16'h5a5a); // equal
			send_op(1'b0, codes[j], 1'b0, 16'h8000, 16'h7fff);
			send_op(1'b0, codes[j], 1'b0, 16'h7fff, 16'h8000);
			send_op(1'b0, codes[j], 1'b0, 16'h8000, 16'h8000);
		end
		drain_ops();
		report_test("compare min max");
	endtask

	task automatic test_negabs();
		logic [15:0] v;
		err_at_start = errors;
		for (int i = 0; i < 12; i++)
		begin
			case (i)
				0: v = 16'h8000;
				1: v = 16'h0000;
				2: v = 16'h7fff;
				3: v = 16'hffff;
				default: v = rand_bits(16);
			endcase
			send_op(1'b0, 5'b10_001, 1'b0, v, 16'h0000);
			send_op(1'b0, 5'b11_001, 1'b0, v, 16'h0000);
		end
		drain_ops();
		report_test("negate and abs");
	endtask

	task automatic test_sat();
		err_at_start = errors;
		for (int s = 1; s >= 0; s--)
		begin
			send_op(1'b0, 5'b00_000, s[0], 16'h7000, 16'h1000); // past max
			send_op(1'b0, 5'b00_000, s[0], 16'h8000, 16'hffff); // past min
			send_op(1'b0, 5'b00_001, s[0], 16'h8000, 16'h0001);
			send_op(1'b0, 5'b00_001, s[0], 16'h7fff, 16'hffff);
			send_op(1'b0, 5'b10_001, s[0], 16'h8000, 16'h0000);
			send_op(1'b0, 5'b11_001, s[0], 16'h8000, 16'h0000);
			for (int i = 0; i < 4; i++)
				send_op(1'b0, {4'b0000, i[0]}, s[0], {i[0], 15'(rand_bits(15))},
					{~i[0], 15'(rand_bits(15))} ^ 16'h4000);
		end
		drain_ops();
		report_test("saturation");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		en = 1'b0;
		log = 1'b0;
		hc = '0;
		sc = '0;
		sat = 1'b0;
		x_in = '0;
		y_in = '0;
		lfsr = SEED;
		model_ac = 1'b0; // flags clear after reset
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		test_logic();
		test_addsub();
		test_carry();
		test_cmp();
		test_negabs();
		test_sat();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* dv/alu_checker.sv */
`timescale 1ns/100ps

module alu_checker
(
	input logic clk,
	input logic reset,
	input logic en,
	input logic log,
	input logic [1:0] hc,
	input logic [2:0] sc,
	input logic [15:0] result,
	input logic az,
	input logic an,
	input logic ac,
	input logic av,
	input logic out_valid
);

	logic is_cmp; // compare op at the inputs

	assign is_cmp = !log && ({hc, sc} == 5'b00_101);

	// ********************************************************************
	// handshake timing
	// ********************************************************************
	// en is captured, then the result lands one edge later
	assert property (@(posedge clk) disable iff (reset) en |-> ##2 out_valid)
		else $error("out_valid missing after en");

	assert property (@(posedge clk) disable iff (reset) out_valid |-> $past(en, 2))
		else $error("out_valid without a matching en");

	// synchronous reset clears every output
	assert property (@(posedge clk) $past(reset) |->
		(result == '0 && !az && !an && !ac && !av && !out_valid))
		else $error("outputs not cleared by reset");

	// zero and negative exclusive except for compare
	assert property (@(posedge clk) disable iff (reset)
		(out_valid && !$past(is_cmp, 2)) |-> !(az && an))
		else $error("az and an both set on a non-compare result");

endmodule

bind alu_top alu_checker alu_checker_inst
(
	.clk(clk),
	.reset(reset),
	.en(en),
	.log(log),
	.hc(hc),
	.sc(sc),
	.result(result),
	.az(az),
	.an(an),
	.ac(ac),
	.av(av),
	.out_valid(out_valid)
);

/* design/alu_top.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_top
(
	input logic clk,
	input logic reset,
	input logic en,
	input logic log,
	input alu_op_pkg::alu_hc_t hc,
	input alu_op_pkg::alu_sc_t sc,
	input logic sat,
	input logic [`ALU_DATA_WIDTH-1:0] x_in,
	input logic [`ALU_DATA_WIDTH-1:0] y_in,
	output logic [`ALU_DATA_WIDTH-1:0] result,
	output logic az,
	output logic an,
	output logic ac,
	output logic av,
	output logic out_valid
);
	import alu_flag_pkg::*;

	alu_operand_if ops_if (); // captured operands and opcode
	logic sat_q;
	logic issue;
	logic carry;              // registered ac back to the adder
	alu_unit_result_t arith_res;
	alu_unit_result_t logic_res;
	alu_flags_t flags;

	// ********************************************************************
	// stage 1, capture
	// ********************************************************************
	alu_operand_stage alu_operand_stage_inst
	(
		.clk(clk),
		.reset(reset),
		.en(en),
		.log(log),
		.hc(hc),
		.sc(sc),
		.sat(sat),
		.x_in(x_in),
		.y_in(y_in),
		.ops(ops_if.capture),
		.sat_q(sat_q),
		.issue(issue)
	);

	// units, combinational
	alu_arith_unit alu_arith_unit_inst
	(
		.ops(ops_if.unit),
		.carry_in(carry),
		.res(arith_res)
	);

	alu_logic_unit alu_logic_unit_inst
	(
		.ops(ops_if.unit),
		.res(logic_res)
	);

	// stage 2, result and flags
	alu_result_stage alu_result_stage_inst
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.sat_q(sat_q),
		.ops(ops_if.unit),
		.arith_res(arith_res),
		.logic_res(logic_res),
		.result(result),
		.flags(flags),
		.carry_out(carry),
		.out_valid(out_valid)
	);

	// flags out as plain ports
	assign az = flags.az;
	assign an = flags.an;
	assign ac = flags.ac;
	assign av = flags.av;

endmodule

/* design/alu_result_stage.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_result_stage
(
	input logic clk,
	input logic reset,
	input logic issue,
	input logic sat_q,
	alu_operand_if.unit ops,
	input alu_flag_pkg::alu_unit_result_t arith_res,
	input alu_flag_pkg::alu_unit_result_t logic_res,
	output logic [`ALU_DATA_WIDTH-1:0] result,
	output alu_flag_pkg::alu_flags_t flags,
	output logic carry_out,
	output logic out_valid
);
	import alu_op_pkg::*;
	import alu_flag_pkg::*;

	localparam int W = `ALU_DATA_WIDTH;

	alu_unit_result_t sel; // chosen unit result
	logic sat_hit;
	logic is_cmp;
	logic [W-1:0] data_d;
	alu_flags_t flags_d;

	assign sel = ops.log ? logic_res : arith_res;
	assign sat_hit = sat_q & sel.av;
	assign is_cmp = !ops.log && (ops.opcode.arith == AOP_CMP);

	// ********************************************************************
	// saturation and zero flag
	// ********************************************************************
	always_comb
	begin
		data_d = sel.data;
		if (sat_hit)
			data_d = sel.sat_pos ? `ALU_SAT_POS : `ALU_SAT_NEG; // clamp toward true sign
		flags_d.az = is_cmp ? sel.eq : (data_d == '0);
		flags_d.an = sat_hit ? ~sel.sat_pos : sel.an; // follow the clamped word
		flags_d.ac = sel.ac;
		flags_d.av = sel.av; // stays set even when clamped
	end

	// output register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			flags <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= issue; // single-cycle pulse per op
			if (issue)
			begin
				result <= data_d;
				flags <= flags_d;
			end
		end
	end

	assign carry_out = flags.ac; // feeds addc/subb of the next op

endmodule

/* design/alu_logic_unit.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_logic_unit
(
	alu_operand_if.unit ops,
	output alu_flag_pkg::alu_unit_result_t res
);
	import alu_op_pkg::*;

	localparam int W = `ALU_DATA_WIDTH;

	alu_logic_op_t op;

	assign op = ops.opcode.logic_op; // logic view of the word

	always_comb
	begin
		res = '0; // carry, overflow, eq stay clear
		if (!op.unary)
		begin
			case (op.sel)
				LSEL_AND: res.data = ops.x & ops.y;
				LSEL_OR:  res.data = ops.x | ops.y;
				LSEL_XOR: res.data = ops.x ^ ops.y;
				default: ;
			endcase
		end
		else if (op.sel == LSEL_NOT)
			res.data = ~ops.x;
		res.an = res.data[W-1];
	end

endmodule

/* design/alu_arith_unit.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_arith_unit
(
	alu_operand_if.unit ops,
	input logic carry_in,
	output alu_flag_pkg::alu_unit_result_t res
);
	import alu_op_pkg::*;

	localparam int W = `ALU_DATA_WIDTH;

	alu_arith_op_t op;
	logic [W-1:0] add_a; // adder operands after unary/invert muxing
	logic [W-1:0] add_b;
	logic add_cin;
	logic [W:0] sum;     // 17 bits with carry on top
	logic add_ov;
	logic lt;            // signed x < y
	logic eq;

	assign op = ops.opcode.arith;

	// ********************************************************************
	// shared adder
	// ********************************************************************
	always_comb
	begin
		add_a = op.hc[1] ? '0 : ops.x;    // neg/abs take 0 + ~x + 1
		add_b = op.hc[1] ? ops.x : ops.y;
		if (op.inv_y)
			add_b = ~add_b;
		// registered ac for addc/subb, else the +1 of a subtract
		add_cin = op.sc_hi[0] ? carry_in : op.inv_y;
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {{W{1'b0}}, add_cin};

	// same-sign inputs with a different-sign output
	assign add_ov = (add_a[W-1] == add_b[W-1]) && (sum[W-1] != add_a[W-1]);

	// true signed compare for cmp/min/max
	assign lt = $signed(ops.x) < $signed(ops.y);
	assign eq = (ops.x == ops.y);

	// ********************************************************************
	// op select and flags
	// ********************************************************************
	always_comb
	begin
		res = '0; // undefined code leaves zero data and clear flags
		case (op)
			AOP_ADD, AOP_SUB, AOP_ADDC, AOP_SUBB, AOP_NEG:
			begin
				res.data = sum[W-1:0];
				res.ac = sum[W];
				res.av = add_ov;
			end
			AOP_ABS:
			begin
				res.data = ops.x[W-1] ? sum[W-1:0] : ops.x;
				res.av = add_ov; // only abs(0x8000)
			end
			AOP_CMP:
			begin
				res.data = ops.x;
				res.eq = eq;
				res.an = lt;
			end
			AOP_MIN: res.data = lt ? ops.x : ops.y;
			AOP_MAX: res.data = lt ? ops.y : ops.x;
			default: ;
		endcase
		if (op != AOP_CMP)
			res.an = res.data[W-1];
		// sign of the unwrapped result flips back on overflow
		res.sat_pos = ~(res.data[W-1] ^ res.av);
	end

endmodule

/* design/alu_operand_stage.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

module alu_operand_stage
(
	input logic clk,
	input logic reset,
	input logic en,
	input logic log,
	input alu_op_pkg::alu_hc_t hc,
	input alu_op_pkg::alu_sc_t sc,
	input logic sat,
	input logic [`ALU_DATA_WIDTH-1:0] x_in,
	input logic [`ALU_DATA_WIDTH-1:0] y_in,
	alu_operand_if.capture ops,
	output logic sat_q,
	output logic issue
);
	import alu_op_pkg::*;

	// ********************************************************************
	// control capture
	// ********************************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issue <= 1'b0;
			sat_q <= 1'b0;
			ops.log <= 1'b0;
			ops.opcode <= '0;
		end
		else
		begin
			issue <= en; // one-cycle copy, result stage loads on it
			if (en)
			begin
				ops.log <= log;
				ops.opcode <= alu_opcode_u'({hc, sc}); // raw word, views decode later
				sat_q <= sat;
			end
		end
	end

	// operand capture
	always_ff @(posedge clk)
	begin
		if (en)
			ops.x <= x_in;
		if (en && !hc[1])
			ops.y <= y_in; // unary ops leave y alone
	end

endmodule

/* design/alu_operand_if.sv */
`timescale 1ns/100ps
`include "alu_cfg.svh"

interface alu_operand_if ();
	import alu_op_pkg::*;

	logic [`ALU_DATA_WIDTH-1:0] x; // captured operands
	logic [`ALU_DATA_WIDTH-1:0] y;
	alu_opcode_u opcode;           // {hc, sc} as captured
	logic log;                     // 1 = logic unit, 0 = arith unit

	// capture stage owns everything
	modport capture (output x, y, opcode, log);

	// units and result stage only look
	modport unit (input x, y, opcode, log);

endinterface

/* design/alu_flag_pkg.sv */
`include "alu_cfg.svh"

package alu_flag_pkg;

	// ********************************************************************
	// status flags as they leave the result stage
	// ********************************************************************
	typedef struct packed {
		logic az; // zero
		logic an; // negative
		logic ac; // carry
		logic av; // overflow
	} alu_flags_t;

	// what each unit hands to the result stage, 21 bits
	typedef struct packed {
		logic [`ALU_DATA_WIDTH-1:0] data;
		logic an;
		logic ac;
		logic av;
		logic sat_pos; // true (unwrapped) result is positive
		logic eq;      // compare only, x == y
	} alu_unit_result_t;

endpackage

/* design/alu_op_pkg.sv */
package alu_op_pkg;

	typedef logic [1:0] alu_hc_t; // high class, opcode bits 21-20
	typedef logic [2:0] alu_sc_t; // subcode, opcode bits 19-17

	// arithmetic view of the opcode word
	typedef struct packed {
		alu_hc_t    hc;    // hc[1] set means unary, adder works on 0 and x
		logic [1:0] sc_hi; // sc[2:1], low bit routes the registered carry in
		logic       inv_y; // sc[0], invert second adder operand
	} alu_arith_op_t;

	// logic view of the same word
	typedef struct packed {
		logic       unary; // only x used
		logic [3:0] sel;   // {hc[0], sc}
	} alu_logic_op_t;

	// one word, read by whichever unit log points at
	typedef union packed {
		alu_arith_op_t arith;
		alu_logic_op_t logic_op;
	} alu_opcode_u;

	// full arithmetic codes {hc, sc}
	localparam logic [4:0] AOP_ADD  = 5'b00_000; // x+y
	localparam logic [4:0] AOP_SUB  = 5'b00_001; // x-y
	localparam logic [4:0] AOP_ADDC = 5'b00_010; // x+y+ci
	localparam logic [4:0] AOP_SUBB = 5'b00_011; // x-y+ci-1
	localparam logic [4:0] AOP_CMP  = 5'b00_101; // comp(x,y)
	localparam logic [4:0] AOP_MIN  = 5'b01_001;
	localparam logic [4:0] AOP_MAX  = 5'b01_011;
	localparam logic [4:0] AOP_NEG  = 5'b10_001; // -x
	localparam logic [4:0] AOP_ABS  = 5'b11_001; // abs x

	// logic select codes
	localparam logic [3:0] LSEL_AND = 4'b0000;
	localparam logic [3:0] LSEL_OR  = 4'b0001;
	localparam logic [3:0] LSEL_XOR = 4'b0010;
	localparam logic [3:0] LSEL_NOT = 4'b1000; // with unary set

endpackage

/* design/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// ********************************************************************
// datapath sizing
// ********************************************************************

`define ALU_DATA_WIDTH 16 // operand and result width

// saturation limits, signed 16-bit words
`define ALU_SAT_POS 16'h7fff // largest positive
`define ALU_SAT_NEG 16'h8000 // most negative

`endif
